// ==== common/dcache_pkg.sv ====
package dcache_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int ADDR_W     = 32;  // byte address
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 8;   // words moved per memory transfer
    localparam int OFFSET_W   = 5;   // byte offset inside a line

    //////////////////////////////
    // vector types
    //////////////////////////////

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [WORD_W/8-1:0]          strb_t;  // one bit per byte lane
    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;  // word 0 in the low bits

    // one cpu load/store request
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
        strb_t wsel;
    } cpu_req_t;

    // miss handling
    typedef enum logic [1:0] {
        ST_LOOKUP,     // request checked against the tags
        ST_WRITEBACK,  // dirty victim going out to memory
        ST_REFILL      // waiting for the line to come back
    } ctrl_state_e;

endpackage

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::cpu_req_t cpu_req_i,

    // from the stores
    input  logic                 hit_i,
    input  logic                 victim_dirty_i,
    input  dcache_pkg::addr_t    victim_addr_i,
    input  dcache_pkg::line_t    victim_line_i,
    input  dcache_pkg::word_t    hit_word_i,

    // memory responses
    input  logic                 mem_rvalid_i,
    input  dcache_pkg::line_t    mem_rdata_i,
    input  logic                 mem_bvalid_i,

    output dcache_pkg::cpu_req_t req_o,
    output logic                 lookup_o,
    output logic                 fill_o,
    output logic                 cpu_data_valid_o,
    output dcache_pkg::word_t    cpu_data_o,
    output logic                 cpu_stall_o,
    output logic                 mem_ren_o,
    output dcache_pkg::addr_t    mem_araddr_o,
    output logic                 mem_wen_o,
    output dcache_pkg::addr_t    mem_awaddr_o,
    output dcache_pkg::line_t    mem_wdata_o
);
    import dcache_pkg::*;

    localparam int WORD_SEL_W = $clog2(LINE_WORDS);

    cpu_req_t              req_q;
    ctrl_state_e           state_q;
    ctrl_state_e           state_d;
    logic                  req_valid;
    logic                  miss;
    addr_t                 wb_addr_q;  // victim held for the writeback
    line_t                 wb_line_q;
    logic [WORD_SEL_W-1:0] word_sel;
    word_t                 fill_word;

    //////////////////////////////
    // request register
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= '0;
        end else if (!cpu_stall_o) begin
            req_q <= cpu_req_i;  // new request only while not stalled
        end
    end

    assign req_o     = req_q;
    assign req_valid = req_q.rd | req_q.wr;
    assign lookup_o  = (state_q == ST_LOOKUP) && req_valid;
    assign miss      = lookup_o && !hit_i;
    assign fill_o    = (state_q == ST_REFILL) && mem_rvalid_i;  // line arrives

    //////////////////////////////
    // miss state machine
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LOOKUP: begin
                if (miss) begin
                    state_d = victim_dirty_i ? ST_WRITEBACK : ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (mem_bvalid_i) begin
                    state_d = ST_REFILL;  // victim is out, fetch the new line
                end
            end
            ST_REFILL: begin
                if (mem_rvalid_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            default: state_d = ST_LOOKUP;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    // capture the victim on the way into writeback
    always_ff @(posedge clk) begin
        if (miss && victim_dirty_i) begin
            wb_addr_q <= victim_addr_i;
            wb_line_q <= victim_line_i;
        end
    end

    // stall from the miss until the refill line shows up
    assign cpu_stall_o = miss
                      || (state_q == ST_WRITEBACK)
                      || ((state_q == ST_REFILL) && !mem_rvalid_i);

    //////////////////////////////
    // memory requests
    //////////////////////////////

    assign mem_wen_o    = (state_q == ST_WRITEBACK);
    assign mem_awaddr_o = wb_addr_q;
    assign mem_wdata_o  = wb_line_q;

    assign mem_ren_o    = (state_q == ST_REFILL) && !mem_rvalid_i;  // drops with the response
    assign mem_araddr_o = {req_q.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    //////////////////////////////
    // cpu response
    //////////////////////////////

    assign word_sel  = req_q.addr[OFFSET_W-1 -: WORD_SEL_W];
    assign fill_word = mem_rdata_i[word_sel*WORD_W +: WORD_W];

    // read hit in lookup, or read miss served straight from the refill
    assign cpu_data_valid_o = req_q.rd && ((lookup_o && hit_i) || fill_o);
    assign cpu_data_o       = fill_o ? fill_word : hit_word_i;

endmodule

// ==== dcache/dcache_tag_store.sv ====
`timescale 1ns/10ps

module dcache_tag_store #(
    parameter int SETS = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::cpu_req_t req_i,
    input  logic                 lookup_i,
    input  logic                 fill_i,
    output logic                 hit_o,
    output logic                 hit_way_o,
    output logic                 victim_way_o,
    output logic                 victim_dirty_o,
    output dcache_pkg::addr_t    victim_addr_o
);
    import dcache_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    tag_t                 tag_q [2][SETS];
    logic [1:0][SETS-1:0] valid_q;
    logic [1:0][SETS-1:0] dirty_q;
    logic [SETS-1:0]      lru_q;  // way to replace next

    index_t     idx;
    tag_t       tag;
    logic [1:0] hit_w;

    assign idx = req_i.addr[OFFSET_W +: INDEX_W];
    assign tag = req_i.addr[ADDR_W-1 -: TAG_W];

    //////////////////////////////
    // hit compare
    //////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_w[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
        end
    end

    assign hit_o     = |hit_w;
    assign hit_way_o = hit_w[1];

    // victim follows the lru bit of the set
    assign victim_way_o   = lru_q[idx];
    assign victim_dirty_o = dirty_q[victim_way_o][idx];
    assign victim_addr_o  = {tag_q[victim_way_o][idx], idx, {OFFSET_W{1'b0}}};

    //////////////////////////////
    // updates
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[victim_way_o][idx] <= tag;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (fill_i) begin
            valid_q[victim_way_o][idx] <= 1'b1;
            dirty_q[victim_way_o][idx] <= req_i.wr;       // write miss lands dirty
            lru_q[idx]                 <= ~victim_way_o;
        end else if (lookup_i && hit_o) begin
            lru_q[idx] <= ~hit_way_o;  // the other way goes next
            if (req_i.wr) begin
                dirty_q[hit_way_o][idx] <= 1'b1;
            end
        end
    end

endmodule

// ==== dcache/dcache_data_store.sv ====
`timescale 1ns/10ps

module dcache_data_store #(
    parameter int SETS = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::cpu_req_t req_i,
    input  logic                 lookup_i,
    input  logic                 fill_i,
    input  logic                 hit_i,
    input  logic                 hit_way_i,
    input  logic                 victim_way_i,
    input  dcache_pkg::line_t    fill_line_i,
    output dcache_pkg::word_t    hit_word_o,
    output dcache_pkg::line_t    victim_line_o
);
    import dcache_pkg::*;

    localparam int INDEX_W    = $clog2(SETS);
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);

    line_t line_q [2][SETS];

    logic [INDEX_W-1:0]    idx;
    logic [WORD_SEL_W-1:0] word_sel;
    line_t                 hit_line;
    word_t                 hit_merged;
    line_t                 fill_merged;
    logic                  hit_we;
    logic                  fill_we;

    // byte lanes picked by sel come from new_w
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t sel);
        word_t res;
        res = old_w;
        for (int b = 0; b < WORD_W/8; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign idx      = req_i.addr[OFFSET_W +: INDEX_W];
    assign word_sel = req_i.addr[OFFSET_W-1 -: WORD_SEL_W];

    //////////////////////////////
    // reads
    //////////////////////////////

    assign hit_line      = line_q[hit_way_i][idx];
    assign hit_word_o    = hit_line[word_sel*WORD_W +: WORD_W];
    assign victim_line_o = line_q[victim_way_i][idx];  // writeback source

    //////////////////////////////
    // writes
    //////////////////////////////

    assign hit_merged = merge_bytes(hit_word_o, req_i.wdata, req_i.wsel);

    // refill line, with the store folded in on a write miss
    always_comb begin
        fill_merged = fill_line_i;
        if (req_i.wr) begin
            fill_merged[word_sel*WORD_W +: WORD_W] =
                merge_bytes(fill_line_i[word_sel*WORD_W +: WORD_W], req_i.wdata, req_i.wsel);
        end
    end

    // arrays hold still during reset
    assign fill_we = fill_i && !rst;
    assign hit_we  = lookup_i && hit_i && req_i.wr && !rst;

    always_ff @(posedge clk) begin
        if (fill_we) begin
            line_q[victim_way_i][idx] <= fill_merged;
        end else if (hit_we) begin
            line_q[hit_way_i][idx][word_sel*WORD_W +: WORD_W] <= hit_merged;
        end
    end

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top #(
    parameter int SETS = 16
) (
    input  logic              clk,
    input  logic              rst,

    // cpu load/store port
    input  logic              cpu_rreq_i,
    input  logic              cpu_wreq_i,
    input  dcache_pkg::addr_t addr_i,
    input  dcache_pkg::word_t cpu_wdata_i,
    input  dcache_pkg::strb_t cpu_wsel_i,
    output logic              cpu_data_valid_o,
    output dcache_pkg::word_t cpu_data_o,
    output logic              cpu_stall_o,

    // line memory
    input  logic              mem_rvalid_i,
    input  dcache_pkg::line_t mem_rdata_i,
    input  logic              mem_bvalid_i,
    output logic              mem_ren_o,
    output dcache_pkg::addr_t mem_araddr_o,
    output logic              mem_wen_o,
    output dcache_pkg::addr_t mem_awaddr_o,
    output dcache_pkg::line_t mem_wdata_o
);
    import dcache_pkg::*;

    cpu_req_t cpu_req;   // raw inputs
    cpu_req_t req;       // registered request in lookup
    logic     lookup;
    logic     fill;
    logic     hit;
    logic     hit_way;
    logic     victim_way;
    logic     victim_dirty;
    addr_t    victim_addr;
    word_t    hit_word;
    line_t    victim_line;

    assign cpu_req = '{
        rd:    cpu_rreq_i,
        wr:    cpu_wreq_i,
        addr:  addr_i,
        wdata: cpu_wdata_i,
        wsel:  cpu_wsel_i
    };

    dcache_ctrl ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .cpu_req_i        (cpu_req),
        .hit_i            (hit),
        .victim_dirty_i   (victim_dirty),
        .victim_addr_i    (victim_addr),
        .victim_line_i    (victim_line),
        .hit_word_i       (hit_word),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .mem_bvalid_i     (mem_bvalid_i),
        .req_o            (req),
        .lookup_o         (lookup),
        .fill_o           (fill),
        .cpu_data_valid_o (cpu_data_valid_o),
        .cpu_data_o       (cpu_data_o),
        .cpu_stall_o      (cpu_stall_o),
        .mem_ren_o        (mem_ren_o),
        .mem_araddr_o     (mem_araddr_o),
        .mem_wen_o        (mem_wen_o),
        .mem_awaddr_o     (mem_awaddr_o),
        .mem_wdata_o      (mem_wdata_o)
    );

    dcache_tag_store #(
        .SETS (SETS)
    ) tag_store_i (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req),
        .lookup_i       (lookup),
        .fill_i         (fill),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_addr_o  (victim_addr)
    );

    dcache_data_store #(
        .SETS (SETS)
    ) data_store_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req),
        .lookup_i      (lookup),
        .fill_i        (fill),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .victim_way_i  (victim_way),
        .fill_line_i   (mem_rdata_i),
        .hit_word_o    (hit_word),
        .victim_line_o (victim_line)
    );

endmodule

// ==== sim/dcache_assertions.sv ====
`timescale 1ns/10ps

module dcache_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 cpu_rreq_i,
    input logic                 cpu_wreq_i,
    input dcache_pkg::addr_t    addr_i,
    input dcache_pkg::word_t    cpu_wdata_i,
    input dcache_pkg::strb_t    cpu_wsel_i,
    input logic                 cpu_data_valid_o,
    input dcache_pkg::word_t    cpu_data_o,
    input logic                 cpu_stall_o,
    input logic                 mem_ren_o,
    input dcache_pkg::addr_t    mem_araddr_o,
    input logic                 mem_wen_o,
    input dcache_pkg::addr_t    mem_awaddr_o,
    input dcache_pkg::line_t    mem_wdata_o
);
    import dcache_pkg::*;

    int    err_count = 0;
    word_t shadow [128];  // bytes 0..511, all the stimulus can reach
    word_t exp_word;
    logic  accept;
    logic  repeat_rd;
    logic  rd_open_q;     // accepted read still owed its data
    logic  prev_rd_q;
    addr_t last_addr_q;
    logic  wb_ok;

    task automatic count_failure(string msg);
        err_count++;
        $error("error at %0t: %s", $time, msg);
    endtask

    assign accept    = !cpu_stall_o && (cpu_rreq_i || cpu_wreq_i);
    assign repeat_rd = accept && cpu_rreq_i && prev_rd_q && (addr_i == last_addr_q);
    assign exp_word  = shadow[last_addr_q[8:2]];

    //////////////////////////////
    // shadow memory
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 128; i++) begin
                shadow[i] <= word_t'(i * 4);  // same start as the memory model
            end
            rd_open_q   <= 1'b0;
            prev_rd_q   <= 1'b0;
            last_addr_q <= '0;
        end else if (accept) begin
            for (int b = 0; b < WORD_W/8; b++) begin
                if (cpu_wreq_i && cpu_wsel_i[b]) begin
                    shadow[addr_i[8:2]][b*8 +: 8] <= cpu_wdata_i[b*8 +: 8];
                end
            end
            rd_open_q   <= cpu_rreq_i;
            prev_rd_q   <= cpu_rreq_i;
            last_addr_q <= addr_i;
        end else if (cpu_data_valid_o) begin
            rd_open_q <= 1'b0;  // answered, nothing owed
        end
    end

    // victim line against the shadow, word by word
    always_comb begin
        wb_ok = 1'b1;
        for (int w = 0; w < LINE_WORDS; w++) begin
            if (mem_wdata_o[w*WORD_W +: WORD_W] != shadow[{mem_awaddr_o[8:5], 3'(w)}]) begin
                wb_ok = 1'b0;
            end
        end
    end

    //////////////////////////////
    // properties
    //////////////////////////////

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !cpu_stall_o && !cpu_data_valid_o && !mem_ren_o && !mem_wen_o)
        else count_failure("outputs not idle after reset");

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        cpu_data_valid_o |-> rd_open_q && cpu_data_o == exp_word)
        else count_failure("read data differs from the shadow memory");

    a_read_once: assert property (@(posedge clk) disable iff (rst)
        accept |-> !rd_open_q || cpu_data_valid_o)
        else count_failure("request accepted before the previous read got its data");

    a_repeat_hit: assert property (@(posedge clk) disable iff (rst)
        repeat_rd |=> cpu_data_valid_o && !cpu_stall_o)
        else count_failure("repeated read did not hit in the next cycle");

    a_writeback: assert property (@(posedge clk) disable iff (rst)
        mem_wen_o |-> wb_ok && mem_awaddr_o[OFFSET_W-1:0] == '0)
        else count_failure("writeback line or address differs from the shadow memory");

    a_mem_side: assert property (@(posedge clk) disable iff (rst)
        (mem_ren_o || mem_wen_o) |-> cpu_stall_o && !(mem_ren_o && mem_wen_o)
            && (!mem_ren_o || mem_araddr_o[OFFSET_W-1:0] == '0))
        else count_failure("memory request outside a stall, overlapping or unaligned");

endmodule

// ==== sim/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int N_REQ  = 400;
    localparam int CLK_NS = 4;

    logic  clk;
    logic  rst;
    logic  cpu_rreq_i;
    logic  cpu_wreq_i;
    addr_t addr_i;
    word_t cpu_wdata_i;
    strb_t cpu_wsel_i;
    logic  cpu_data_valid_o;
    word_t cpu_data_o;
    logic  cpu_stall_o;
    logic  mem_rvalid_i;
    line_t mem_rdata_i;
    logic  mem_bvalid_i;
    logic  mem_ren_o;
    addr_t mem_araddr_o;
    logic  mem_wen_o;
    addr_t mem_awaddr_o;
    line_t mem_wdata_o;
    word_t mem [128];  // line memory, bytes 0..511
    addr_t req_addr;
    logic  req_rd;
    int    kind;
    int    errs;

    dcache_top #(.SETS (4)) dut_i (.*);  // 4 sets so evictions come often

    bind dcache_top dcache_checker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        void'($urandom(32'hc5813864));
        for (int i = 0; i < 128; i++) begin
            mem[i] = word_t'(i * 4);  // each word holds its own byte address
        end
        rst          = 1'b1;
        cpu_rreq_i   = 1'b0;
        cpu_wreq_i   = 1'b0;
        addr_i       = '0;
        cpu_wdata_i  = '0;
        cpu_wsel_i   = '0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        mem_bvalid_i = 1'b0;
        req_rd       = 1'b0;
        req_addr     = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < N_REQ; n++) begin
            kind = $urandom % 10;
            // 64-word window: words 0..3 of 16 lines, four lines per set
            if (!(kind < 3 && req_rd)) begin
                req_addr = {23'd0, 4'($urandom), 3'($urandom % 4), 2'b00};
            end
            req_rd = !(kind >= 3 && kind < 6);  // kinds 3..5 write
            cpu_rreq_i  <= req_rd;
            cpu_wreq_i  <= !req_rd;
            addr_i      <= req_addr;
            cpu_wdata_i <= $urandom;
            cpu_wsel_i  <= 4'($urandom);
            do @(posedge clk); while (cpu_stall_o);  // until accepted
        end
        cpu_rreq_i <= 1'b0;
        cpu_wreq_i <= 1'b0;
        do @(posedge clk); while (cpu_stall_o);  // last miss drains
        repeat (4) @(posedge clk);
        errs = dut_i.checker_i.err_count;
        $display("run done: %0d requests, %0d assertion failures", N_REQ, errs);
        if (errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    //////////////////////////////
    // memory model
    //////////////////////////////

    initial begin
        forever begin
            @(posedge clk);
            if (!rst && (mem_wen_o || mem_ren_o)) begin
                repeat ($urandom % 8) @(posedge clk);  // 1 to 8 cycles to the pulse
                if (mem_wen_o) begin
                    for (int w = 0; w < LINE_WORDS; w++) begin
                        mem[{mem_awaddr_o[8:5], 3'(w)}] = mem_wdata_o[w*WORD_W +: WORD_W];
                    end
                    mem_bvalid_i <= 1'b1;
                end else begin
                    for (int w = 0; w < LINE_WORDS; w++) begin
                        mem_rdata_i[w*WORD_W +: WORD_W] <= mem[{mem_araddr_o[8:5], 3'(w)}];
                    end
                    mem_rvalid_i <= 1'b1;
                end
                @(posedge clk);
                mem_bvalid_i <= 1'b0;  // one cycle pulse
                mem_rvalid_i <= 1'b0;
            end
        end
    end

    // watchdog
    initial begin
        #(N_REQ * 40 * CLK_NS);
        $display("timeout: run not finished after %0d cycles", N_REQ * 40);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
common/dcache_pkg.sv
dcache/dcache_ctrl.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_store.sv
verilog/dcache_top.sv
sim/dcache_assertions.sv
sim/dcache_tb.sv
